// File: include/matMul_macros.svh
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// grid edge length, rows and columns alike
`define MM_DIM 4

// operand and result byte width
`define MM_DATA_W 8

// one SRAM address lane
`define MM_ADDR_W 11

// walking along a row of A
`define MM_A_STEP 1

// walking down a column of B, also the row pitch of both matrices
`define MM_B_STEP 4

`endif

// File: logic/arrayPkg.sv
`default_nettype none

`include "matMul_macros.svh"

package arrayPkg;

	// one operand or accumulated result
	typedef logic [`MM_DATA_W-1:0] elemT;

	// one bit per cell, index r*DIM + c
	typedef logic [`MM_DIM*`MM_DIM-1:0] cellMaskT;

	// all cell results, row-major
	typedef elemT [`MM_DIM*`MM_DIM-1:0] resultGridT;

endpackage

`default_nettype wire

// File: logic/memPkg.sv
`default_nettype none

`include "matMul_macros.svh"

package memPkg;

	typedef logic [`MM_ADDR_W-1:0] laneAddrT;

	// lane 0 in the low bits
	typedef laneAddrT [`MM_DIM-1:0] addrBusT;

	// byte lane i at bits i*8 +: 8
	typedef logic [`MM_DIM*`MM_DATA_W-1:0] memWordT;

	typedef logic [`MM_DIM-1:0] laneMaskT;

	typedef enum logic [1:0] {
		IDLE,
		FEED,
		DRAIN,
		FINISH
	} ctrlStateT;

endpackage

`default_nettype wire

// File: logic/operandIf.sv
`default_nettype none

// skewed operand bytes on their way into the grid edges
interface operandIf;

	memPkg::memWordT aBytes;
	memPkg::memWordT bBytes;
	memPkg::laneMaskT aValid;
	memPkg::laneMaskT bValid;

	modport feed (output aBytes, bBytes, aValid, bValid);
	modport grid (input aBytes, bBytes, aValid, bValid);

endinterface

`default_nettype wire

// File: logic/matMulCtrl.sv
`default_nettype none

`include "matMul_macros.svh"

module matMulCtrl (
	input logic clk,
	input logic rst_n,
	input logic start,
	output memPkg::addrBusT aAddr,
	output memPkg::addrBusT bAddr,
	input memPkg::memWordT aData,
	input memPkg::memWordT bData,
	operandIf.feed ops,
	input logic allWritten,
	output logic finish
);

	memPkg::ctrlStateT state;
	logic [2:0] step;
	memPkg::laneMaskT laneActive;
	memPkg::laneMaskT activeQ;
	memPkg::addrBusT aHeld;
	memPkg::addrBusT bHeld;

	// lane i carries element k = step - i while it is active
	always_comb begin
		int k;
		for (int i = 0; i < `MM_DIM; i++) begin
			k = int'(step) - i;
			laneActive[i] = (state == memPkg::FEED) && (k >= 0) && (k < `MM_DIM);
			if (laneActive[i]) begin
				aAddr[i] = memPkg::laneAddrT'(i * `MM_B_STEP + k * `MM_A_STEP);
				bAddr[i] = memPkg::laneAddrT'(k * `MM_B_STEP + i * `MM_A_STEP);
			end else begin
				aAddr[i] = aHeld[i];
				bAddr[i] = bHeld[i];
			end
		end
	end

	// data comes back one cycle after its address
	always_comb begin
		for (int i = 0; i < `MM_DIM; i++) begin
			ops.aBytes[i*`MM_DATA_W +: `MM_DATA_W] =
				activeQ[i] ? aData[i*`MM_DATA_W +: `MM_DATA_W] : '0;
			ops.bBytes[i*`MM_DATA_W +: `MM_DATA_W] =
				activeQ[i] ? bData[i*`MM_DATA_W +: `MM_DATA_W] : '0;
		end
		ops.aValid = activeQ;
		ops.bValid = activeQ;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= memPkg::IDLE;
			step <= '0;
			activeQ <= '0;
			for (int i = 0; i < `MM_DIM; i++) begin
				aHeld[i] <= memPkg::laneAddrT'(i * `MM_B_STEP);
				bHeld[i] <= memPkg::laneAddrT'(i * `MM_A_STEP);
			end
		end else begin
			activeQ <= laneActive;
			aHeld <= aAddr;
			bHeld <= bAddr;
			case (state)
				memPkg::IDLE: begin
					if (start) begin
						state <= memPkg::FEED;
						step <= '0;
					end
				end
				memPkg::FEED: begin
					// last lane starts DIM-1 late and runs DIM steps
					if (int'(step) == 2 * `MM_DIM - 2) begin
						state <= memPkg::DRAIN;
					end else begin
						step <= step + 3'd1;
					end
				end
				memPkg::DRAIN: begin
					if (allWritten) begin
						state <= memPkg::FINISH;
					end
				end
				default: begin
					state <= memPkg::IDLE;
				end
			endcase
		end
	end

	assign finish = (state == memPkg::FINISH);

	// a run never restarts from a busy state
	assert property (@(posedge clk) disable iff (!rst_n)
		(start && state != memPkg::IDLE) |=> !(state == memPkg::FEED && step == '0));

	// each lane stays valid for exactly one row or column
	for (genvar lane = 0; lane < `MM_DIM; lane++) begin : gLaneCheck
		assert property (@(posedge clk) disable iff (!rst_n)
			$rose(activeQ[lane]) |-> activeQ[lane] [*`MM_DIM] ##1 !activeQ[lane]);
	end

endmodule

`default_nettype wire

// File: logic/peCell.sv
`default_nettype none

`include "matMul_macros.svh"

module peCell (
	input logic clk,
	input logic rst_n,
	input arrayPkg::elemT aIn,
	input arrayPkg::elemT bIn,
	input logic validIn,
	output arrayPkg::elemT aOut,
	output arrayPkg::elemT bOut,
	output logic validOut,
	output arrayPkg::elemT result,
	output logic done
);

	logic [$clog2(`MM_DIM)-1:0] sampleCnt;
	arrayPkg::elemT acc;
	arrayPkg::elemT prod;

	// product wraps at 8 bits, as does the sum
	assign prod = aIn * bIn;
	assign result = acc;

	always_ff @(posedge clk) begin
		aOut <= aIn;
		bOut <= bIn;
		if (validIn) begin
			// first sample of a run restarts the sum
			if (sampleCnt == '0) begin
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sampleCnt <= '0;
			validOut <= 1'b0;
			done <= 1'b0;
		end else begin
			validOut <= validIn;
			done <= validIn && (int'(sampleCnt) == `MM_DIM - 1);
			// wraps back to zero after the last sample
			if (validIn) begin
				sampleCnt <= sampleCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/peArray.sv
`default_nettype none

`include "matMul_macros.svh"

module peArray (
	input logic clk,
	input logic rst_n,
	operandIf.grid ops,
	output arrayPkg::cellMaskT doneVec,
	output arrayPkg::resultGridT results
);

	// right and down links, one per cell
	arrayPkg::elemT aLink [`MM_DIM][`MM_DIM];
	arrayPkg::elemT bLink [`MM_DIM][`MM_DIM];
	logic vLink [`MM_DIM][`MM_DIM];

	for (genvar r = 0; r < `MM_DIM; r++) begin : gRow
		for (genvar c = 0; c < `MM_DIM; c++) begin : gCol
			arrayPkg::elemT aIn;
			arrayPkg::elemT bIn;
			logic aSide;
			logic bSide;

			if (c == 0) begin : gLeftEdge
				assign aIn = ops.aBytes[r*`MM_DATA_W +: `MM_DATA_W];
				assign aSide = ops.aValid[r];
			end else begin : gLeftLink
				assign aIn = aLink[r][c-1];
				assign aSide = vLink[r][c-1];
			end

			if (r == 0) begin : gTopEdge
				assign bIn = ops.bBytes[c*`MM_DATA_W +: `MM_DATA_W];
				assign bSide = ops.bValid[c];
			end else begin : gTopLink
				assign bIn = bLink[r-1][c];
				assign bSide = vLink[r-1][c];
			end

			peCell uCell (
				.clk(clk),
				.rst_n(rst_n),
				.aIn(aIn),
				.bIn(bIn),
				.validIn(aSide & bSide),
				.aOut(aLink[r][c]),
				.bOut(bLink[r][c]),
				.validOut(vLink[r][c]),
				.result(results[r*`MM_DIM + c]),
				.done(doneVec[r*`MM_DIM + c])
			);

			// skew from the controller keeps both wavefronts in step
			assert property (@(posedge clk) disable iff (!rst_n) aSide == bSide);
		end
	end

endmodule

`default_nettype wire

// File: logic/resultWriter.sv
`default_nettype none

`include "matMul_macros.svh"

module resultWriter (
	input logic clk,
	input logic rst_n,
	input arrayPkg::cellMaskT doneVec,
	input arrayPkg::resultGridT results,
	output memPkg::addrBusT cAddr,
	output memPkg::memWordT cData,
	output memPkg::laneMaskT cWriteN,
	output logic allWritten
);

	memPkg::laneMaskT hit;
	memPkg::addrBusT nextAddr;
	memPkg::memWordT nextData;
	logic [$clog2(`MM_DIM):0] hitCnt;
	logic [$clog2(`MM_DIM*`MM_DIM):0] writeCnt;
	logic [$clog2(`MM_DIM*`MM_DIM):0] writeSum;
	logic [`MM_DIM-1:0] colDone [`MM_DIM];

	// byte lane = column, address = row of the finishing cell
	always_comb begin
		hit = '0;
		nextAddr = '0;
		nextData = '0;
		hitCnt = '0;
		for (int c = 0; c < `MM_DIM; c++) begin
			for (int r = 0; r < `MM_DIM; r++) begin
				colDone[c][r] = doneVec[r*`MM_DIM + c];
				if (doneVec[r*`MM_DIM + c]) begin
					hit[c] = 1'b1;
					nextAddr[c] = memPkg::laneAddrT'(r);
					nextData[c*`MM_DATA_W +: `MM_DATA_W] = results[r*`MM_DIM + c];
				end
			end
			hitCnt = hitCnt + hit[c];
		end
	end

	assign writeSum = writeCnt + hitCnt;

	always_ff @(posedge clk) begin
		cAddr <= nextAddr;
		cData <= nextData;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cWriteN <= '1;
			writeCnt <= '0;
			allWritten <= 1'b0;
		end else begin
			cWriteN <= ~hit;
			allWritten <= (int'(writeSum) == `MM_DIM * `MM_DIM);
			if (int'(writeSum) == `MM_DIM * `MM_DIM) begin
				writeCnt <= '0;
			end else begin
				writeCnt <= writeSum;
			end
		end
	end

	// grid skew puts each cell of a column on its own cycle
	for (genvar c = 0; c < `MM_DIM; c++) begin : gColCheck
		assert property (@(posedge clk) disable iff (!rst_n) $onehot0(colDone[c]));
	end

endmodule

`default_nettype wire

// File: logic/matMulTop.sv
`default_nettype none

module matMulTop (
	input logic clk,
	input logic rst_n,
	input logic start,
	output memPkg::addrBusT aAddr,
	output memPkg::addrBusT bAddr,
	input memPkg::memWordT aData,
	input memPkg::memWordT bData,
	output memPkg::addrBusT cAddr,
	output memPkg::memWordT cData,
	output memPkg::laneMaskT cWriteN,
	output logic finish
);

	arrayPkg::cellMaskT doneVec;
	arrayPkg::resultGridT results;
	logic allWritten;

	operandIf opsBus ();

	matMulCtrl uCtrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.aAddr(aAddr),
		.bAddr(bAddr),
		.aData(aData),
		.bData(bData),
		.ops(opsBus.feed),
		.allWritten(allWritten),
		.finish(finish)
	);

	peArray uArray (
		.clk(clk),
		.rst_n(rst_n),
		.ops(opsBus.grid),
		.doneVec(doneVec),
		.results(results)
	);

	resultWriter uWriter (
		.clk(clk),
		.rst_n(rst_n),
		.doneVec(doneVec),
		.results(results),
		.cAddr(cAddr),
		.cData(cData),
		.cWriteN(cWriteN),
		.allWritten(allWritten)
	);

endmodule

`default_nettype wire

// File: tb/resultChecker.sv
`default_nettype none

`include "matMul_macros.svh"

module resultChecker (
	input logic clk,
	input logic rst_n,
	input arrayPkg::elemT aMat [`MM_DIM*`MM_DIM],
	input arrayPkg::elemT bMat [`MM_DIM*`MM_DIM],
	input logic runOpen,
	input logic expectB,
	input logic checkConst,
	input arrayPkg::elemT constByte,
	input memPkg::addrBusT aAddr,
	input memPkg::addrBusT bAddr,
	input memPkg::addrBusT cAddr,
	input memPkg::memWordT cData,
	input memPkg::laneMaskT cWriteN,
	input logic finish,
	output int errorCount,
	output int writeCount,
	output int finishCount
);

	int cellWrites [`MM_DIM*`MM_DIM];
	int resetCycles;
	int row;
	logic finishQ;
	arrayPkg::elemT got;
	arrayPkg::elemT want;

	// reference product, the sum wraps at 8 bits
	function automatic arrayPkg::elemT productAt(input int r, input int c);
		logic [2*`MM_DATA_W-1:0] prod;
		arrayPkg::elemT sum;
		sum = '0;
		for (int k = 0; k < `MM_DIM; k++) begin
			prod = aMat[r*`MM_DIM + k] * bMat[k*`MM_DIM + c];
			sum = sum + prod[`MM_DATA_W-1:0];
		end
		return sum;
	endfunction

	task automatic reportValue(input string what, input int r, input int c,
			input arrayPkg::elemT seen, input arrayPkg::elemT expected);
		$display("Error at %0t: %s C[%0d][%0d] is %02h, expected %02h",
			$time, what, r, c, seen, expected);
		errorCount++;
	endtask

	task automatic reportProblem(input string what);
		$display("At time %0t something went wrong: %s", $time, what);
		errorCount++;
	endtask

	initial begin
		errorCount = 0;
		writeCount = 0;
		finishCount = 0;
		resetCycles = 0;
		finishQ = 1'b0;
		for (int i = 0; i < `MM_DIM*`MM_DIM; i++) begin
			cellWrites[i] = 0;
		end
	end

	// outputs are sampled before this edge updates them
	always @(posedge clk) begin
		if (!rst_n) begin
			resetCycles++;
			// the first reset edge is what clears them
			if (resetCycles > 1 && (cWriteN !== '1 || finish !== 1'b0)) begin
				reportProblem("C write enables or finish are active during reset");
			end
			// row i of A starts at i*DIM, column i of B at i
			for (int i = 0; i < `MM_DIM; i++) begin
				if (resetCycles > 1 && (aAddr[i] !== memPkg::laneAddrT'(i * `MM_DIM) ||
						bAddr[i] !== memPkg::laneAddrT'(i))) begin
					reportProblem("an address lane is not at its base during reset");
				end
			end
			finishQ = 1'b0;
			for (int i = 0; i < `MM_DIM*`MM_DIM; i++) begin
				cellWrites[i] = 0;
			end
		end else begin
			for (int c = 0; c < `MM_DIM; c++) begin
				if (cWriteN[c] === 1'b0) begin
					writeCount++;
					row = int'(cAddr[c]);
					got = cData[c*`MM_DATA_W +: `MM_DATA_W];
					if (!runOpen) begin
						reportProblem("a C write came while no run was open");
					end
					if (row >= `MM_DIM) begin
						reportProblem("a C write addressed a row outside the matrix");
					end else begin
						cellWrites[row*`MM_DIM + c]++;
						want = productAt(row, c);
						if (got !== want) begin
							reportValue("product", row, c, got, want);
						end
						if (expectB && got !== bMat[row*`MM_DIM + c]) begin
							reportValue("identity", row, c, got, bMat[row*`MM_DIM + c]);
						end
						if (checkConst && got !== constByte) begin
							reportValue("constant", row, c, got, constByte);
						end
					end
				end else if (cWriteN[c] !== 1'b1) begin
					reportProblem("a C write enable is unknown");
				end
			end

			if (finish === 1'b1) begin
				finishCount++;
				if (finishQ) begin
					reportProblem("finish stayed high for more than one cycle");
				end
				if (!runOpen) begin
					reportProblem("finish came while no run was open");
				end
				if (cWriteN !== '1) begin
					reportProblem("a C write came in the same cycle as finish");
				end
				// every cell exactly once per run
				for (int i = 0; i < `MM_DIM*`MM_DIM; i++) begin
					if (cellWrites[i] != 1) begin
						reportProblem($sformatf("cell %0d,%0d was written %0d times",
							i / `MM_DIM, i % `MM_DIM, cellWrites[i]));
					end
					cellWrites[i] = 0;
				end
			end else if (finish !== 1'b0) begin
				reportProblem("finish is unknown");
			end
			finishQ = finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/tbMatMul.sv
`default_nettype none

`include "matMul_macros.svh"

module tbMatMul;

	localparam int NUM_CASES = 5;
	localparam int CELLS = `MM_DIM * `MM_DIM;
	localparam int CYCLES_PER_CASE = 200;
	localparam int RESET_CYCLES = 10;
	localparam logic [CELLS*`MM_DATA_W-1:0] IDENTITY = 128'h01000000_00010000_00000100_00000001;
	localparam logic [CELLS*`MM_DATA_W-1:0] B_PATTERN = 128'hf0e1d2c3_b4a59687_78695a4b_3c2d1e0f;
	localparam logic [CELLS*`MM_DATA_W-1:0] ALL_ONES = '1;

	typedef struct packed {
		logic randomFill;
		logic [CELLS*`MM_DATA_W-1:0] aInit;
		logic [CELLS*`MM_DATA_W-1:0] bInit;
		// cycles after start, 0 for none
		int extraStart;
		logic expectB;
		logic checkConst;
		logic [`MM_DATA_W-1:0] constByte;
	} caseT;

	logic clk;
	logic rst_n;
	logic start;
	logic runOpen;
	memPkg::addrBusT aAddr;
	memPkg::addrBusT bAddr;
	memPkg::addrBusT cAddr;
	memPkg::memWordT aData;
	memPkg::memWordT bData;
	memPkg::memWordT cData;
	memPkg::laneMaskT cWriteN;
	logic finish;
	arrayPkg::elemT aMem [CELLS];
	arrayPkg::elemT bMem [CELLS];
	caseT cases [NUM_CASES];
	logic expectB;
	logic checkConst;
	arrayPkg::elemT constByte;
	logic [31:0] lfsrState;
	int errorCount;
	int writeCount;
	int finishCount;
	int runErrors;

	matMulTop u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.aAddr(aAddr),
		.bAddr(bAddr),
		.aData(aData),
		.bData(bData),
		.cAddr(cAddr),
		.cData(cData),
		.cWriteN(cWriteN),
		.finish(finish)
	);

	resultChecker uCheck (
		.clk(clk),
		.rst_n(rst_n),
		.aMat(aMem),
		.bMat(bMem),
		.runOpen(runOpen),
		.expectB(expectB),
		.checkConst(checkConst),
		.constByte(constByte),
		.aAddr(aAddr),
		.bAddr(bAddr),
		.cAddr(cAddr),
		.cData(cData),
		.cWriteN(cWriteN),
		.finish(finish),
		.errorCount(errorCount),
		.writeCount(writeCount),
		.finishCount(finishCount)
	);

	always #4 clk = ~clk;

	// synchronous read, data one cycle after the address
	always @(posedge clk) begin
		for (int i = 0; i < `MM_DIM; i++) begin
			aData[i*`MM_DATA_W +: `MM_DATA_W] <= aMem[aAddr[i]];
			bData[i*`MM_DATA_W +: `MM_DATA_W] <= bMem[bAddr[i]];
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomByte(output arrayPkg::elemT b);
		b = '0;
		for (int i = 0; i < `MM_DATA_W; i++) begin
			lfsrState = lfsrNext(lfsrState);
			b = {b[`MM_DATA_W-2:0], lfsrState[0]};
		end
	endtask

	task automatic loadCase(input caseT tc);
		arrayPkg::elemT b;
		for (int i = 0; i < CELLS; i++) begin
			if (tc.randomFill) begin
				randomByte(b);
				aMem[i] <= b;
				randomByte(b);
				bMem[i] <= b;
			end else begin
				aMem[i] <= tc.aInit[i*`MM_DATA_W +: `MM_DATA_W];
				bMem[i] <= tc.bInit[i*`MM_DATA_W +: `MM_DATA_W];
			end
		end
		expectB <= tc.expectB;
		checkConst <= tc.checkConst;
		constByte <= tc.constByte;
	endtask

	task automatic runCase(input caseT tc);
		@(posedge clk);
		loadCase(tc);
		@(posedge clk);
		start <= 1'b1;
		runOpen <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// a second start while the run is busy
		if (tc.extraStart > 0) begin
			repeat (tc.extraStart - 1) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		@(posedge clk);
		while (finish !== 1'b1) begin
			@(posedge clk);
		end
		runOpen <= 1'b0;
	endtask

	initial begin
		#((NUM_CASES * CYCLES_PER_CASE + RESET_CYCLES) * 8);
		$display("Timeout: finish never came within %0d cycles per table entry",
			CYCLES_PER_CASE);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		runOpen = 1'b0;
		aData = '0;
		bData = '0;
		expectB = 1'b0;
		checkConst = 1'b0;
		constByte = '0;
		lfsrState = 32'h5028cab2;
		runErrors = 0;
		for (int i = 0; i < CELLS; i++) begin
			aMem[i] = '0;
			bMem[i] = '0;
		end

		// random, A, B, extra start, C equals B, constant check, constant
		cases[0] = '{1'b0, IDENTITY, B_PATTERN, 0, 1'b1, 1'b0, 8'h00};
		cases[1] = '{1'b0, ALL_ONES, ALL_ONES, 0, 1'b0, 1'b1, 8'h04};
		cases[2] = '{1'b1, '0, '0, 0, 1'b0, 1'b0, 8'h00};
		cases[3] = '{1'b1, '0, '0, 3, 1'b0, 1'b0, 8'h00};
		cases[4] = '{1'b1, '0, '0, 10, 1'b0, 1'b0, 8'h00};

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (int n = 0; n < NUM_CASES; n++) begin
			runCase(cases[n]);
		end
		repeat (4) @(posedge clk);

		if (finishCount != NUM_CASES) begin
			$display("finish pulsed %0d times over %0d runs", finishCount, NUM_CASES);
			runErrors++;
		end
		$display("checker errors %0d, run errors %0d, C writes %0d, finish pulses %0d",
			errorCount, runErrors, writeCount, finishCount);
		if (errorCount == 0 && runErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
logic/arrayPkg.sv
logic/memPkg.sv
logic/operandIf.sv
logic/matMulCtrl.sv
logic/peCell.sv
logic/peArray.sv
logic/resultWriter.sv
logic/matMulTop.sv
tb/resultChecker.sv
tb/tbMatMul.sv

// File: Bender.yml
package:
  name: matmul

export_include_dirs:
  - include

sources:
  - logic/arrayPkg.sv
  - logic/memPkg.sv
  - logic/operandIf.sv
  - logic/matMulCtrl.sv
  - logic/peCell.sv
  - logic/peArray.sv
  - logic/resultWriter.sv
  - logic/matMulTop.sv
  - target: simulation
    files:
      - tb/resultChecker.sv
      - tb/tbMatMul.sv
